//--- pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  localparam int XLEN = 64;
  localparam int FLAG_W = 4;
  localparam int REG_AW = 4;
  localparam int NUM_REGS = 16;

  // bit positions in the flag nibble
  localparam int FLAG_Z = 0;
  localparam int FLAG_S = 1;
  localparam int FLAG_C = 2;
  localparam int FLAG_O = 3;

  typedef logic [XLEN-1:0] data_t;
  typedef logic [FLAG_W-1:0] flags_t;
  typedef logic [REG_AW-1:0] reg_addr_t;

endpackage

`default_nettype wire

//--- isa_pkg.sv
`default_nettype none

package isa_pkg;

  localparam int INSN_W = 40;

  typedef logic [3:0] op_code_t;
  typedef logic [3:0] reg_idx_t;
  typedef logic [21:0] imm_t;

  typedef enum logic [1:0] {
    FMT_REG = 2'd0,
    FMT_IMM = 2'd1,
    FMT_BR  = 2'd2,  // not supported here
    FMT_MEM = 2'd3   // not supported here
  } fmt_e;

  typedef enum logic [3:0] {
    C_AL, C_NV, C_EQ, C_NE, C_CS, C_CC, C_MI, C_PL,
    C_VS, C_VC, C_HI, C_LS, C_GE, C_LT, C_GT, C_LE
  } cond_e;

  // register ops take codes 0..11, immediate ops are remapped to 12 and 13
  typedef enum logic [3:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR, OP_SAR,
    OP_SXT8, OP_SXT16, OP_SXT32, OP_BSWAP, OP_ADDI, OP_LUI
  } alu_op_e;

  // op field values in the immediate format
  localparam op_code_t IMM_OP_ADDI = 4'd0;
  localparam op_code_t IMM_OP_LUI = 4'd1;

  typedef struct packed {
    fmt_e       fmt;
    cond_e      cond;
    op_code_t   op;
    reg_idx_t   rd;
    reg_idx_t   ra;
    reg_idx_t   rb;
    logic [17:0] pad;
  } reg_insn_t;

  typedef struct packed {
    fmt_e     fmt;
    cond_e    cond;
    op_code_t op;
    reg_idx_t rd;
    reg_idx_t ra;
    imm_t     imm;
  } imm_insn_t;

  typedef union packed {
    reg_insn_t r;
    imm_insn_t i;
  } insn_u;

endpackage

`default_nettype wire

//--- exec_ifs.sv
`timescale 1ns/1ps
`default_nettype none

interface rd_if;
  logic fwd_a;
  logic fwd_b;
  logic [pipe_pkg::REG_AW-1:0] ra_addr;
  logic [pipe_pkg::REG_AW-1:0] rb_addr;
  logic [pipe_pkg::XLEN-1:0] ra_data;
  logic [pipe_pkg::XLEN-1:0] rb_data;
  logic [pipe_pkg::FLAG_W-1:0] ra_flags;  // file flags before forwarding

  modport ctrl (input ra_addr, input rb_addr, input ra_flags, output fwd_a, output fwd_b);
  modport dec (output ra_addr, output rb_addr);
  modport rf (
    input fwd_a, input fwd_b, input ra_addr, input rb_addr,
    output ra_data, output rb_data, output ra_flags
  );
  // extra view so int_alu can sample the operands at E1
  modport alu (input ra_data, input rb_data);
endinterface

interface wb_if;
  logic we;
  logic [pipe_pkg::REG_AW-1:0] rd;
  logic [pipe_pkg::XLEN-1:0] data;
  logic [pipe_pkg::FLAG_W-1:0] flags;

  modport ctrl (output we, output rd);
  modport alu (output data, output flags);
  modport rf (input we, input rd, input data, input flags);
endinterface

`default_nettype wire

//--- shift_ext_unit.sv
`timescale 1ns/1ps
`default_nettype none

module shift_ext_unit (
  input  isa_pkg::alu_op_e          op,
  input  logic [pipe_pkg::XLEN-1:0] a,
  input  logic [pipe_pkg::XLEN-1:0] b,
  output logic [pipe_pkg::XLEN-1:0] res
);

  localparam int XL = pipe_pkg::XLEN;

  logic [5:0] shamt;

  assign shamt = b[5:0];

  always_comb begin
    case (op)
      isa_pkg::OP_SHL:   res = a << shamt;
      isa_pkg::OP_SHR:   res = a >> shamt;
      isa_pkg::OP_SAR:   res = $signed(a) >>> shamt;
      isa_pkg::OP_SXT8:  res = {{(XL-8){a[7]}}, a[7:0]};
      isa_pkg::OP_SXT16: res = {{(XL-16){a[15]}}, a[15:0]};
      isa_pkg::OP_SXT32: res = {{(XL-32){a[31]}}, a[31:0]};
      // low word byte-reversed, upper half cleared
      isa_pkg::OP_BSWAP: res = {{(XL-32){1'b0}}, a[7:0], a[15:8], a[23:16], a[31:24]};
      default:           res = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- insn_decode.sv
`timescale 1ns/1ps
`default_nettype none

module insn_decode (
  input  isa_pkg::insn_u                insn,
  input  logic                          insn_valid,
  rd_if.dec                             rd_bus,
  output isa_pkg::alu_op_e              dec_op,
  output isa_pkg::cond_e                dec_cond,
  output logic [pipe_pkg::REG_AW-1:0]   dec_rd,
  output logic [pipe_pkg::XLEN-1:0]     dec_imm,
  output logic                          dec_use_imm,
  output logic                          dec_legal
);

  localparam int IMM_W = $bits(isa_pkg::imm_t);

  logic [pipe_pkg::XLEN-1:0] imm_sx;

  assign imm_sx = {{(pipe_pkg::XLEN-IMM_W){insn.i.imm[IMM_W-1]}}, insn.i.imm};

  // ra sits in the same place in both layouts
  assign rd_bus.ra_addr = insn.r.ra;
  assign rd_bus.rb_addr = insn.r.rb;  // imm bits for FMT_IMM where b is unused

  always_comb begin
    dec_op = isa_pkg::OP_ADD;
    dec_cond = insn.r.cond;
    dec_rd = insn.r.rd;
    dec_imm = '0;
    dec_use_imm = 1'b0;
    dec_legal = 1'b0;
    case (insn.r.fmt)
      isa_pkg::FMT_REG: begin
        dec_op = isa_pkg::alu_op_e'(insn.r.op);
        dec_legal = insn.r.op <= isa_pkg::OP_BSWAP;  // 12..15 reserved
      end
      isa_pkg::FMT_IMM: begin
        dec_use_imm = 1'b1;
        if (insn.i.op == isa_pkg::IMM_OP_LUI) begin
          dec_op = isa_pkg::OP_LUI;
          dec_imm = imm_sx << 32;
        end else begin
          dec_op = isa_pkg::OP_ADDI;
          dec_imm = imm_sx;
        end
        dec_legal = insn.i.op == isa_pkg::IMM_OP_ADDI || insn.i.op == isa_pkg::IMM_OP_LUI;
      end
      isa_pkg::FMT_BR, isa_pkg::FMT_MEM: dec_legal = 1'b0;  // dropped formats
      default: dec_legal = 1'b0;
    endcase
    if (!insn_valid) dec_legal = 1'b0;
  end

endmodule

`default_nettype wire

//--- pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
  input  logic                          clk,
  input  logic                          rst,
  input  isa_pkg::alu_op_e              dec_op,
  input  isa_pkg::cond_e                dec_cond,
  input  logic [pipe_pkg::REG_AW-1:0]   dec_rd,
  input  logic                          dec_legal,
  input  logic [pipe_pkg::FLAG_W-1:0]   ex_flags_fwd,
  rd_if.ctrl                            rd_bus,
  wb_if.ctrl                            wb_bus,
  output isa_pkg::alu_op_e              ex_op
);

  logic                          ex_valid;
  isa_pkg::cond_e                ex_cond;
  logic [pipe_pkg::REG_AW-1:0]   ex_rd;
  logic [pipe_pkg::FLAG_W-1:0]   ex_flags;  // ra flags of the execute instruction
  logic [pipe_pkg::FLAG_W-1:0]   ra_flags_sel;
  logic                          ex_we;
  logic                          fwd_a;
  logic                          fwd_b;

  function automatic logic cond_true(isa_pkg::cond_e c, logic [pipe_pkg::FLAG_W-1:0] f);
    logic z;
    logic s;
    logic cy;
    logic o;
    z = f[pipe_pkg::FLAG_Z];
    s = f[pipe_pkg::FLAG_S];
    cy = f[pipe_pkg::FLAG_C];
    o = f[pipe_pkg::FLAG_O];
    case (c)
      isa_pkg::C_AL: cond_true = 1'b1;
      isa_pkg::C_NV: cond_true = 1'b0;
      isa_pkg::C_EQ: cond_true = z;
      isa_pkg::C_NE: cond_true = !z;
      isa_pkg::C_CS: cond_true = cy;
      isa_pkg::C_CC: cond_true = !cy;
      isa_pkg::C_MI: cond_true = s;
      isa_pkg::C_PL: cond_true = !s;
      isa_pkg::C_VS: cond_true = o;
      isa_pkg::C_VC: cond_true = !o;
      isa_pkg::C_HI: cond_true = cy && !z;
      isa_pkg::C_LS: cond_true = !cy || z;
      isa_pkg::C_GE: cond_true = s == o;
      isa_pkg::C_LT: cond_true = s != o;
      isa_pkg::C_GT: cond_true = !z && (s == o);
      isa_pkg::C_LE: cond_true = z || (s != o);
      default: cond_true = 1'b0;
    endcase
  endfunction

  assign ex_we = ex_valid && cond_true(ex_cond, ex_flags);

  // only the directly preceding instruction can be in flight
  assign fwd_a = ex_we && (rd_bus.ra_addr == ex_rd);
  assign fwd_b = ex_we && (rd_bus.rb_addr == ex_rd);
  assign rd_bus.fwd_a = fwd_a;
  assign rd_bus.fwd_b = fwd_b;

  assign ra_flags_sel = fwd_a ? ex_flags_fwd : rd_bus.ra_flags;

  always_ff @(posedge clk) begin
    if (rst) ex_valid <= 1'b0;
    else ex_valid <= dec_legal;
    ex_op <= dec_op;
    ex_cond <= dec_cond;
    ex_rd <= dec_rd;
    ex_flags <= ra_flags_sel;
  end

  assign wb_bus.we = ex_we;
  assign wb_bus.rd = ex_rd;

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                          clk,
  input  logic                          rst,
  rd_if.rf                              rd_bus,
  wb_if.rf                              wb_bus,
  output logic                          wb_valid,
  output logic [pipe_pkg::REG_AW-1:0]   wb_rd,
  output logic [pipe_pkg::XLEN-1:0]     wb_data,
  output logic [pipe_pkg::FLAG_W-1:0]   wb_flags
);

  logic [pipe_pkg::XLEN-1:0]   regs  [pipe_pkg::NUM_REGS];
  logic [pipe_pkg::FLAG_W-1:0] flags [pipe_pkg::NUM_REGS];

  // data bypass from the execute result
  assign rd_bus.ra_data = rd_bus.fwd_a ? wb_bus.data : regs[rd_bus.ra_addr];
  assign rd_bus.rb_data = rd_bus.fwd_b ? wb_bus.data : regs[rd_bus.rb_addr];
  assign rd_bus.ra_flags = flags[rd_bus.ra_addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < pipe_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
        flags[i] <= '0;
      end
    end else if (wb_bus.we) begin
      regs[wb_bus.rd] <= wb_bus.data;
      flags[wb_bus.rd] <= wb_bus.flags;
    end
  end

  // writeback report registered at E2
  always_ff @(posedge clk) begin
    if (rst) wb_valid <= 1'b0;
    else wb_valid <= wb_bus.we;
    if (wb_bus.we) begin
      wb_rd <= wb_bus.rd;
      wb_data <= wb_bus.data;
      wb_flags <= wb_bus.flags;
    end
  end

endmodule

`default_nettype wire

//--- int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu (
  input  logic                          clk,
  input  logic                          rst,
  input  isa_pkg::alu_op_e              ex_op,
  input  logic [pipe_pkg::XLEN-1:0]     dec_imm,
  input  logic                          dec_use_imm,
  rd_if.alu                             rd_bus,
  wb_if.alu                             wb_bus,
  output logic [pipe_pkg::FLAG_W-1:0]   ex_flags_fwd
);

  localparam int MSB = pipe_pkg::XLEN - 1;

  logic [pipe_pkg::XLEN-1:0]   op_a;
  logic [pipe_pkg::XLEN-1:0]   op_b;
  logic [pipe_pkg::XLEN:0]     sum;
  logic [pipe_pkg::XLEN:0]     diff;
  logic [pipe_pkg::XLEN-1:0]   shx_res;
  logic [pipe_pkg::XLEN-1:0]   res;
  logic                        carry;
  logic                        ovf;
  logic [pipe_pkg::FLAG_W-1:0] flags_new;

  always_ff @(posedge clk) begin
    if (rst) begin
      op_a <= '0;
      op_b <= '0;
    end else begin
      op_a <= rd_bus.ra_data;
      op_b <= dec_use_imm ? dec_imm : rd_bus.rb_data;
    end
  end

  assign sum = {1'b0, op_a} + {1'b0, op_b};
  assign diff = {1'b0, op_a} + {1'b0, ~op_b} + 1'b1;  // carry set means no borrow

  shift_ext_unit i_shift_ext_unit (
    .op  (ex_op),
    .a   (op_a),
    .b   (op_b),
    .res (shx_res)
  );

  always_comb begin
    res = shx_res;
    carry = 1'b0;
    ovf = 1'b0;
    case (ex_op)
      isa_pkg::OP_ADD, isa_pkg::OP_ADDI: begin
        res = sum[MSB:0];
        carry = sum[pipe_pkg::XLEN];
        ovf = (op_a[MSB] == op_b[MSB]) && (sum[MSB] != op_a[MSB]);
      end
      isa_pkg::OP_SUB: begin
        res = diff[MSB:0];
        carry = diff[pipe_pkg::XLEN];
        ovf = (op_a[MSB] != op_b[MSB]) && (diff[MSB] != op_a[MSB]);
      end
      isa_pkg::OP_AND: res = op_a & op_b;
      isa_pkg::OP_OR:  res = op_a | op_b;
      isa_pkg::OP_XOR: res = op_a ^ op_b;
      isa_pkg::OP_LUI: res = op_b;  // imm already shifted by decode
      default: res = shx_res;
    endcase
  end

  always_comb begin
    flags_new = '0;
    flags_new[pipe_pkg::FLAG_Z] = res == '0;
    flags_new[pipe_pkg::FLAG_S] = res[MSB];
    flags_new[pipe_pkg::FLAG_C] = carry;
    flags_new[pipe_pkg::FLAG_O] = ovf;
  end

  assign wb_bus.data = res;
  assign wb_bus.flags = flags_new;
  assign ex_flags_fwd = flags_new;  // for a dependent condition next cycle

endmodule

`default_nettype wire

//--- exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          insn_valid,
  input  logic [isa_pkg::INSN_W-1:0]    insn,
  output logic                          wb_valid,
  output logic [pipe_pkg::REG_AW-1:0]   wb_rd,
  output logic [pipe_pkg::XLEN-1:0]     wb_data,
  output logic [pipe_pkg::FLAG_W-1:0]   wb_flags
);

  isa_pkg::alu_op_e              dec_op;
  isa_pkg::cond_e                dec_cond;
  logic [pipe_pkg::REG_AW-1:0]   dec_rd;
  logic [pipe_pkg::XLEN-1:0]     dec_imm;
  logic                          dec_use_imm;
  logic                          dec_legal;
  isa_pkg::alu_op_e              ex_op;
  logic [pipe_pkg::FLAG_W-1:0]   ex_flags_fwd;

  rd_if rd_bus ();
  wb_if wb_bus ();

  insn_decode i_insn_decode (
    .insn        (insn),
    .insn_valid  (insn_valid),
    .rd_bus      (rd_bus),
    .dec_op      (dec_op),
    .dec_cond    (dec_cond),
    .dec_rd      (dec_rd),
    .dec_imm     (dec_imm),
    .dec_use_imm (dec_use_imm),
    .dec_legal   (dec_legal)
  );

  pipe_ctrl i_pipe_ctrl (
    .clk          (clk),
    .rst          (rst),
    .dec_op       (dec_op),
    .dec_cond     (dec_cond),
    .dec_rd       (dec_rd),
    .dec_legal    (dec_legal),
    .ex_flags_fwd (ex_flags_fwd),
    .rd_bus       (rd_bus),
    .wb_bus       (wb_bus),
    .ex_op        (ex_op)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rd_bus   (rd_bus),
    .wb_bus   (wb_bus),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .wb_flags (wb_flags)
  );

  int_alu i_int_alu (
    .clk          (clk),
    .rst          (rst),
    .ex_op        (ex_op),
    .dec_imm      (dec_imm),
    .dec_use_imm  (dec_use_imm),
    .rd_bus       (rd_bus),
    .wb_bus       (wb_bus),
    .ex_flags_fwd (ex_flags_fwd)
  );

endmodule

`default_nettype wire

//--- exec_checker.sv
`timescale 1ns/1ps
`default_nettype none

module exec_checker (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          insn_valid,
  input  logic [isa_pkg::INSN_W-1:0]    insn,
  input  logic                          wb_valid,
  input  logic [pipe_pkg::REG_AW-1:0]   wb_rd,
  input  logic [pipe_pkg::XLEN-1:0]     wb_data,
  input  logic [pipe_pkg::FLAG_W-1:0]   wb_flags,
  output int                            value_errors,
  output int                            timing_errors
);

  typedef struct packed {
    logic [31:0]                 due;
    logic [pipe_pkg::REG_AW-1:0] rd;
    logic [pipe_pkg::XLEN-1:0]   data;
    logic [pipe_pkg::FLAG_W-1:0] flags;
  } wb_exp_t;

  logic [pipe_pkg::XLEN-1:0]   model_regs  [pipe_pkg::NUM_REGS];
  logic [pipe_pkg::FLAG_W-1:0] model_flags [pipe_pkg::NUM_REGS];
  wb_exp_t                     expected [$];
  logic [31:0]                 cycle;

  initial begin
    value_errors = 0;
    timing_errors = 0;
    cycle = 0;
  end

  function automatic logic cond_holds(input logic [3:0] cond, input logic [3:0] f);
    logic z;
    logic s;
    logic c;
    logic o;
    z = f[pipe_pkg::FLAG_Z];
    s = f[pipe_pkg::FLAG_S];
    c = f[pipe_pkg::FLAG_C];
    o = f[pipe_pkg::FLAG_O];
    case (cond)
      isa_pkg::C_AL: return 1'b1;
      isa_pkg::C_NV: return 1'b0;
      isa_pkg::C_EQ: return z;
      isa_pkg::C_NE: return !z;
      isa_pkg::C_CS: return c;
      isa_pkg::C_CC: return !c;
      isa_pkg::C_MI: return s;
      isa_pkg::C_PL: return !s;
      isa_pkg::C_VS: return o;
      isa_pkg::C_VC: return !o;
      isa_pkg::C_HI: return c && !z;
      isa_pkg::C_LS: return !c || z;
      isa_pkg::C_GE: return s == o;
      isa_pkg::C_LT: return s != o;
      isa_pkg::C_GT: return !z && (s == o);
      default:       return z || (s != o);  // C_LE
    endcase
  endfunction

  // models one instruction in program order and queues its writeback
  task automatic model_insn(input logic [isa_pkg::INSN_W-1:0] word);
    isa_pkg::insn_u              u;
    logic [3:0]                  op;
    logic [pipe_pkg::XLEN-1:0]   a;
    logic [pipe_pkg::XLEN-1:0]   b;
    logic [pipe_pkg::XLEN-1:0]   r;
    logic [pipe_pkg::XLEN:0]     wide;
    logic                        c;
    logic                        o;
    logic                        legal;
    logic [pipe_pkg::FLAG_W-1:0] f;
    wb_exp_t                     e;
    u = word;
    op = 4'd0;
    a = model_regs[u.r.ra];
    b = model_regs[u.r.rb];
    r = '0;
    c = 1'b0;
    o = 1'b0;
    legal = 1'b1;
    case (u.r.fmt)
      isa_pkg::FMT_REG: begin
        op = u.r.op;
        legal = u.r.op <= 4'd11;
      end
      isa_pkg::FMT_IMM: begin
        b = {{(pipe_pkg::XLEN-22){u.i.imm[21]}}, u.i.imm};
        if (u.i.op == 4'd0) op = isa_pkg::OP_ADDI;
        else if (u.i.op == 4'd1) op = isa_pkg::OP_LUI;
        else legal = 1'b0;
      end
      default: legal = 1'b0;  // branch and memory formats
    endcase
    case (op)
      isa_pkg::OP_ADD, isa_pkg::OP_ADDI: begin
        wide = {1'b0, a} + {1'b0, b};
        r = wide[pipe_pkg::XLEN-1:0];
        c = wide[pipe_pkg::XLEN];
        o = (a[63] == b[63]) && (r[63] != a[63]);
      end
      isa_pkg::OP_SUB: begin
        r = a - b;
        c = a >= b;  // no borrow
        o = (a[63] != b[63]) && (r[63] != a[63]);
      end
      isa_pkg::OP_AND:   r = a & b;
      isa_pkg::OP_OR:    r = a | b;
      isa_pkg::OP_XOR:   r = a ^ b;
      isa_pkg::OP_SHL:   r = a << b[5:0];
      isa_pkg::OP_SHR:   r = a >> b[5:0];
      isa_pkg::OP_SAR:   r = $signed(a) >>> b[5:0];
      isa_pkg::OP_SXT8:  r = {{56{a[7]}}, a[7:0]};
      isa_pkg::OP_SXT16: r = {{48{a[15]}}, a[15:0]};
      isa_pkg::OP_SXT32: r = {{32{a[31]}}, a[31:0]};
      isa_pkg::OP_BSWAP: r = {32'h0, a[7:0], a[15:8], a[23:16], a[31:24]};
      isa_pkg::OP_LUI:   r = b << 32;
      default:           legal = 1'b0;
    endcase
    if (legal && cond_holds(u.r.cond, model_flags[u.r.ra])) begin
      f = '0;
      f[pipe_pkg::FLAG_Z] = r == '0;
      f[pipe_pkg::FLAG_S] = r[63];
      f[pipe_pkg::FLAG_C] = c;
      f[pipe_pkg::FLAG_O] = o;
      model_regs[u.r.rd] = r;
      model_flags[u.r.rd] = f;
      e.due = cycle + 2;  // two edges after sampling
      e.rd = u.r.rd;
      e.data = r;
      e.flags = f;
      expected.push_back(e);
    end
  endtask

  task automatic check_writeback();
    wb_exp_t e;
    if (expected.size() > 0 && expected[0].due == cycle) begin
      e = expected.pop_front();
      if (wb_valid !== 1'b1) begin
        timing_errors++;
        $display("[ERROR] %0t: missing writeback to r%0d, expected data %h",
                 $time, e.rd, e.data);
      end else if (wb_rd !== e.rd || wb_data !== e.data || wb_flags !== e.flags) begin
        value_errors++;
        $display("[ERROR] %0t: got r%0d %h flags %h, expected r%0d %h flags %h",
                 $time, wb_rd, wb_data, wb_flags, e.rd, e.data, e.flags);
      end
    end else if (wb_valid === 1'b1) begin
      timing_errors++;
      $display("[ERROR] %0t: unexpected writeback to r%0d", $time, wb_rd);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      if (wb_valid === 1'b1) begin
        timing_errors++;
        $display("[ERROR] %0t: wb_valid high during reset", $time);
      end
      for (int i = 0; i < pipe_pkg::NUM_REGS; i++) begin
        model_regs[i] = '0;
        model_flags[i] = '0;
      end
      expected.delete();
      cycle = 0;
    end else begin
      cycle = cycle + 1;
      check_writeback();
      if (insn_valid) model_insn(insn);
    end
  end

endmodule

`default_nettype wire

//--- tb_exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_cluster;

  localparam int RUN_CYCLES = 3000;
  localparam int DRAIN_CYCLES = 8;
  localparam int TIMEOUT_CYCLES = RUN_CYCLES + 100;  // reset, drain and margin

  logic                          clk;
  logic                          rst;
  logic                          insn_valid;
  logic [isa_pkg::INSN_W-1:0]    insn;
  logic                          wb_valid;
  logic [pipe_pkg::REG_AW-1:0]   wb_rd;
  logic [pipe_pkg::XLEN-1:0]     wb_data;
  logic [pipe_pkg::FLAG_W-1:0]   wb_flags;
  int                            value_errors;
  int                            timing_errors;
  int                            cycles = 0;
  logic [31:0]                   lfsr = 32'h4e01;

  exec_cluster i_exec_cluster (
    .clk        (clk),
    .rst        (rst),
    .insn_valid (insn_valid),
    .insn       (insn),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .wb_flags   (wb_flags)
  );

  exec_checker i_exec_checker (
    .clk           (clk),
    .rst           (rst),
    .insn_valid    (insn_valid),
    .insn          (insn),
    .wb_valid      (wb_valid),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data),
    .wb_flags      (wb_flags),
    .value_errors  (value_errors),
    .timing_errors (timing_errors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic build_insn(output logic valid, output logic [isa_pkg::INSN_W-1:0] word);
    logic [31:0] v;
    logic [1:0]  fmt;
    logic [3:0]  cond;
    logic [33:0] rest;  // op, rd, ra, then rb or imm
    draw_bits(2, v);
    valid = v[1:0] != 2'b00;
    draw_bits(3, v);
    if (v[2:0] == 3'd0) begin
      draw_bits(1, v);
      fmt = v[0] ? isa_pkg::FMT_MEM : isa_pkg::FMT_BR;
    end else begin
      draw_bits(1, v);
      fmt = v[0] ? isa_pkg::FMT_IMM : isa_pkg::FMT_REG;
    end
    draw_bits(2, v);
    if (v[1:0] == 2'b00) begin
      draw_bits(4, v);
      cond = v[3:0];
    end else begin
      cond = isa_pkg::C_AL;
    end
    draw_bits(30, v);
    rest[29:0] = v[29:0];
    draw_bits(4, v);
    rest[33:30] = v[3:0];
    word = {fmt, cond, rest};
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("simulation timed out after %0d cycles", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    logic                       nv;
    logic [isa_pkg::INSN_W-1:0] nw;
    rst = 1'b1;
    insn_valid = 1'b0;
    insn = '0;
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int n = 0; n < RUN_CYCLES; n++) begin
      build_insn(nv, nw);
      insn_valid = nv;
      insn = nw;
      @(posedge clk);
      #2;
    end
    insn_valid = 1'b0;
    repeat (DRAIN_CYCLES) @(posedge clk);
    #2;
    $display("value errors: %0d, timing errors: %0d", value_errors, timing_errors);
    if (value_errors == 0 && timing_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
pipe_pkg.sv
isa_pkg.sv
exec_ifs.sv
shift_ext_unit.sv
insn_decode.sv
pipe_ctrl.sv
reg_file.sv
int_alu.sv
exec_cluster.sv
exec_checker.sv
tb_exec_cluster.sv

//--- run.sh
#!/usr/bin/env bash
verilator --binary --timing -Wno-fatal --top-module tb_exec_cluster -f sources.f \
  -o sim_exec_cluster > build.log 2>&1 \
  && ./obj_dir/sim_exec_cluster > sim.log 2>&1 \
  || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "no result line in sim.log"; exit 1; }
echo "simulation passed"
